/* seqMultiplier.f */
mulArithPkg.sv
mulQueuePkg.sv
operandQueue.sv
shiftAddControl.sv
shiftAddDatapath.sv
seqMultiplier.sv
tbSeqMultiplier.sv

/* tbSeqMultiplier.sv */
module tbSeqMultiplier;
  import mulArithPkg::*;
  import mulQueuePkg::*;

  localparam int randomPairs   = 200;
  localparam int resultTimeout = 40;   // Cycles a pending pair may wait for its product.
  localparam int spaceTimeout  = 60;
  localparam int drainTimeout  = 400;
  localparam int quietCycles   = 40;

  logic                    clk;
  logic                    reset;
  logic                    loadStrobe;
  logic [operandWidth-1:0] multiplicand;
  logic [operandWidth-1:0] multiplier;
  logic                    queueFull;
  logic                    productValid;
  logic [productWidth-1:0] product;

  logic [31:0]             lfsrState;
  logic [operandWidth-1:0] pendingMultiplicand [$];
  logic [operandWidth-1:0] pendingMultiplier [$];
  int                      acceptedCount;
  int                      resultCount;

  seqMultiplier DUT (
    .clk          (clk),
    .reset        (reset),
    .loadStrobe   (loadStrobe),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .queueFull    (queueFull),
    .productValid (productValid),
    .product      (product)
  );

  always #10 clk = ~clk;

  // Galois form with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic logic [productWidth-1:0] referenceProduct(
    input logic [operandWidth-1:0] a,
    input logic [operandWidth-1:0] b
  );
    logic signed [productWidth-1:0] wideA;
    logic signed [productWidth-1:0] wideB;
    wideA = {{operandWidth{a[operandWidth-1]}}, a};
    wideB = {{operandWidth{b[operandWidth-1]}}, b};
    return wideA * wideB;                // Exact because the product fits in 32 bits.
  endfunction

  task automatic reportFailure(input string reason);
    $display("%s at time %0t", reason, $time);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkProduct(input logic [productWidth-1:0] expected,
                              input logic [productWidth-1:0] actual);
    if (actual !== expected) begin
      $display("Error: time %0t product expected %h actual %h", $time, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: time %0t %s expected %b actual %b", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic checkPulseCount();
    if (resultCount != acceptedCount) begin
      $display("Error: time %0t productValid pulses expected %0d actual %0d",
               $time, acceptedCount, resultCount);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic drawOperand(output logic [operandWidth-1:0] value);
    for (int i = 0; i < operandWidth; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value[i] = lfsrState[0];
    end
  endtask

  // Called on a falling edge and returns on the next one.
  task automatic pushPair(input logic [operandWidth-1:0] a, input logic [operandWidth-1:0] b);
    int waited;
    waited = 0;
    while (queueFull) begin
      @(negedge clk);
      waited++;
      if (waited > spaceTimeout) begin
        reportFailure("Timed out waiting for queueFull to fall");
      end
    end
    loadStrobe   = 1'b1;
    multiplicand = a;
    multiplier   = b;
    pendingMultiplicand.push_back(a);
    pendingMultiplier.push_back(b);
    acceptedCount++;
    @(negedge clk);
    loadStrobe = 1'b0;
  endtask

  task automatic waitForProduct();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!productValid) begin
      @(negedge clk);
      waited++;
      if (waited > resultTimeout) begin
        reportFailure("Timed out waiting for a productValid pulse");
      end
    end
  endtask

  task automatic drainResults();
    int waited;
    waited = 0;
    while (pendingMultiplicand.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > drainTimeout) begin
        reportFailure("Timed out waiting for all pending products");
      end
    end
    repeat (quietCycles) @(negedge clk);  // Extra pulses would show up here.
    checkPulseCount();
  endtask

  // Distinct pulses, so a stretched productValid counts once.
  always @(posedge productValid) begin
    resultCount++;
  end

  // Every pulse must match the oldest pair still pending.
  initial begin : resultChecker
    int                      idleCycles;
    logic [operandWidth-1:0] a;
    logic [operandWidth-1:0] b;
    idleCycles = 0;
    forever begin
      @(negedge clk);
      if (productValid) begin
        if (pendingMultiplicand.size() == 0) begin
          reportFailure("productValid pulsed with no pair pending");
        end
        a = pendingMultiplicand.pop_front();
        b = pendingMultiplier.pop_front();
        checkProduct(referenceProduct(a, b), product);
        idleCycles = 0;
      end else if (pendingMultiplicand.size() != 0) begin
        idleCycles++;
        if (idleCycles > resultTimeout) begin
          reportFailure("Timed out waiting for productValid of a pending pair");
        end
      end else begin
        idleCycles = 0;
      end
    end
  end

  initial begin : stimulus
    logic [operandWidth-1:0] a;
    logic [operandWidth-1:0] b;
    clk           = 1'b0;
    reset         = 1'b0;
    loadStrobe    = 1'b0;
    multiplicand  = '0;
    multiplier    = '0;
    lfsrState     = 32'hd5bf_4ca6;
    acceptedCount = 0;
    resultCount   = 0;
    repeat (10) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    checkFlag("queueFull", 1'b0, queueFull);
    checkProduct('0, product);

    // Corner operands that hit the negated sign step in both directions.
    pushPair(16'h0000, 16'h7abc);
    pushPair(16'h9e37, 16'h0000);
    pushPair(16'h0001, 16'h8123);
    pushPair(16'hffff, 16'hffff);
    pushPair(16'h8000, 16'h8000);
    pushPair(16'h8000, 16'h7fff);
    pushPair(16'h7fff, 16'h8000);
    pushPair(16'h7fff, 16'h7fff);
    drainResults();

    for (int i = 0; i < randomPairs; i++) begin
      drawOperand(a);
      drawOperand(b);
      pushPair(a, b);
    end
    drainResults();

    // One pair in the engine plus queueDepth waiting.
    for (int i = 0; i <= queueDepth; i++) begin
      drawOperand(a);
      drawOperand(b);
      checkFlag("queueFull", 1'b0, queueFull);
      pushPair(a, b);
    end
    checkFlag("queueFull", 1'b1, queueFull);
    pushPair(16'h8000, 16'hffff);
    pushPair(16'h1234, 16'hfedc);
    drainResults();

    // Reset while a pair is in the engine and more are queued.
    for (int i = 0; i <= queueDepth; i++) begin
      drawOperand(a);
      drawOperand(b);
      pushPair(a, b);
    end
    waitForProduct();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    acceptedCount = acceptedCount - pendingMultiplicand.size();
    pendingMultiplicand.delete();
    pendingMultiplier.delete();
    repeat (3) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    checkProduct('0, product);
    checkFlag("queueFull", 1'b0, queueFull);
    for (int i = 0; i < quietCycles; i++) begin
      @(negedge clk);
      if (productValid) begin
        reportFailure("productValid pulsed after reset with no new push");
      end
    end

    pushPair(16'h8000, 16'h8000);
    pushPair(16'hffff, 16'h0001);
    for (int i = 0; i < 10; i++) begin
      drawOperand(a);
      drawOperand(b);
      pushPair(a, b);
    end
    drainResults();

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* seqMultiplier.sv */
module seqMultiplier (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 loadStrobe,
  input  logic [mulArithPkg::operandWidth-1:0] multiplicand,
  input  logic [mulArithPkg::operandWidth-1:0] multiplier,
  output logic                                 queueFull,
  output logic                                 productValid,
  output logic [mulArithPkg::productWidth-1:0] product
);
  import mulArithPkg::*;

  logic [operandWidth-1:0] headMultiplicand;
  logic [operandWidth-1:0] headMultiplier;
  logic [stepWidth-1:0]    stepIndex;

  logic queueEmpty;
  logic pop;
  logic load;
  logic clearSum;
  logic step;
  logic negateStep;
  logic capture;

  operandQueue queue (
    .clk              (clk),
    .reset            (reset),
    .push             (loadStrobe),
    .pop              (pop),
    .pushMultiplicand (multiplicand),
    .pushMultiplier   (multiplier),
    .headMultiplicand (headMultiplicand),
    .headMultiplier   (headMultiplier),
    .full             (queueFull),
    .empty            (queueEmpty)
  );

  shiftAddControl control (
    .clk          (clk),
    .reset        (reset),
    .queueEmpty   (queueEmpty),
    .stepIndex    (stepIndex),
    .pop          (pop),
    .load         (load),
    .clearSum     (clearSum),
    .step         (step),
    .negateStep   (negateStep),
    .capture      (capture),
    .productValid (productValid)
  );

  shiftAddDatapath datapath (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .clearSum     (clearSum),
    .step         (step),
    .negateStep   (negateStep),
    .capture      (capture),
    .multiplicand (headMultiplicand),  // Head pair is valid in the pop cycle.
    .multiplier   (headMultiplier),
    .stepIndex    (stepIndex),
    .product      (product)
  );

endmodule

/* shiftAddDatapath.sv */
module shiftAddDatapath (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 load,
  input  logic                                 clearSum,
  input  logic                                 step,
  input  logic                                 negateStep,
  input  logic                                 capture,
  input  logic [mulArithPkg::operandWidth-1:0] multiplicand,
  input  logic [mulArithPkg::operandWidth-1:0] multiplier,
  output logic [mulArithPkg::stepWidth-1:0]    stepIndex,
  output logic [mulArithPkg::productWidth-1:0] product
);
  import mulArithPkg::*;

  logic [operandWidth-1:0] multiplicandReg;
  logic [operandWidth-1:0] multiplierReg;

  logic [productWidth-1:0] partialSum;
  logic [productWidth-1:0] extendedMultiplicand;
  logic [productWidth-1:0] selectedTerm;
  logic [productWidth-1:0] signedTerm;
  logic [productWidth-1:0] shiftedTerm;
  logic [productWidth-1:0] sumNext;

  logic multiplierBit;

  // Operand registers.
  always_ff @(posedge clk) begin
    if (load) begin
      multiplicandReg <= multiplicand;
      multiplierReg   <= multiplier;
    end
  end

  // Step counter.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      stepIndex <= '0;
    end else if (load) begin
      stepIndex <= '0;
    end else if (step) begin
      stepIndex <= stepIndex + 1'b1;  // Wraps to zero after the sign step.
    end
  end

  assign multiplierBit = multiplierReg[stepIndex];

  assign extendedMultiplicand = {{operandWidth{multiplicandReg[operandWidth-1]}},
                                 multiplicandReg};

  assign selectedTerm = multiplierBit ? extendedMultiplicand : '0;

  // Bit 15 weighs -2^15 in two's complement.
  assign signedTerm = negateStep ? (~selectedTerm + productWidth'(1)) : selectedTerm;

  assign shiftedTerm = signedTerm << stepIndex;

  assign sumNext = partialSum + shiftedTerm;

  // Partial sum.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      partialSum <= '0;
    end else if (clearSum) begin
      partialSum <= '0;               // Wins over step.
    end else if (step) begin
      partialSum <= sumNext;
    end
  end

  // Result register, held until the next capture.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      product <= '0;
    end else if (capture) begin
      product <= partialSum;
    end
  end

  // Negation only makes sense on a step that adds a term.
  negateOnlyOnStep: assert property (
    @(posedge clk) disable iff (!reset)
    negateStep |-> step
  ) else $error("shiftAddDatapath negateStep without step");

endmodule

/* shiftAddControl.sv */
module shiftAddControl (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              queueEmpty,
  input  logic [mulArithPkg::stepWidth-1:0] stepIndex,
  output logic                              pop,
  output logic                              load,
  output logic                              clearSum,
  output logic                              step,
  output logic                              negateStep,
  output logic                              capture,
  output logic                              productValid
);
  import mulArithPkg::*;

  localparam logic [1:0] stateIdle    = 2'd0;
  localparam logic [1:0] stateRun     = 2'd1;
  localparam logic [1:0] stateCapture = 2'd2;
  localparam logic [1:0] stateDone    = 2'd3;

  logic [1:0] state;
  logic [1:0] stateNext;

  logic startPair;
  logic finalStep;

  // Done behaves like idle so the next pair starts without a gap.
  assign startPair = ((state == stateIdle) || (state == stateDone)) && !queueEmpty;

  assign finalStep = (state == stateRun) && (stepIndex == lastStep);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= stateIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      stateIdle, stateDone: begin
        if (startPair) begin
          stateNext = stateRun;
        end else begin
          stateNext = stateIdle;
        end
      end
      stateRun: begin
        if (finalStep) begin
          stateNext = stateCapture;  // Sign bit was the last term.
        end
      end
      stateCapture: begin
        stateNext = stateDone;
      end
      default: begin
        stateNext = stateIdle;
      end
    endcase
  end

  // Pop cycle also loads the operands and clears the partial sum.
  assign pop      = startPair;
  assign load     = startPair;
  assign clearSum = startPair;

  assign step       = (state == stateRun);
  assign negateStep = finalStep;    // Negative weight of bit 15.
  assign capture    = (state == stateCapture);

  assign productValid = (state == stateDone);

  // Result register must not load while the sum is still moving.
  stepNotWithCapture: assert property (
    @(posedge clk) disable iff (!reset)
    !(step && capture)
  ) else $error("shiftAddControl step and capture together");

  productValidPulse: assert property (
    @(posedge clk) disable iff (!reset)
    productValid |=> !productValid
  ) else $error("shiftAddControl productValid longer than one cycle");

endmodule

/* operandQueue.sv */
module operandQueue (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 push,
  input  logic                                 pop,
  input  logic [mulArithPkg::operandWidth-1:0] pushMultiplicand,
  input  logic [mulArithPkg::operandWidth-1:0] pushMultiplier,
  output logic [mulArithPkg::operandWidth-1:0] headMultiplicand,
  output logic [mulArithPkg::operandWidth-1:0] headMultiplier,
  output logic                                 full,
  output logic                                 empty
);
  import mulArithPkg::*;
  import mulQueuePkg::*;

  logic [operandWidth-1:0] multiplicandMem [queueDepth];
  logic [operandWidth-1:0] multiplierMem [queueDepth];

  logic [queuePtrWidth-1:0] writePtr;
  logic [queuePtrWidth-1:0] readPtr;
  logic [queuePtrWidth:0]   count;    // One extra bit to tell full from empty.

  logic doPush;
  logic doPop;

  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  // Pair storage.
  always_ff @(posedge clk) begin
    if (doPush) begin
      multiplicandMem[writePtr] <= pushMultiplicand;
      multiplierMem[writePtr]   <= pushMultiplier;
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      writePtr <= '0;
    end else if (doPush) begin
      writePtr <= writePtr + 1'b1;  // Wraps at queueDepth.
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      readPtr <= '0;
    end else if (doPop) begin
      readPtr <= readPtr + 1'b1;
    end
  end

  // Occupancy.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      count <= '0;
    end else begin
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push with pop keeps the level.
      endcase
    end
  end

  assign full  = (count == queueDepth);
  assign empty = (count == '0);

  assign headMultiplicand = multiplicandMem[readPtr];
  assign headMultiplier   = multiplierMem[readPtr];

  // The producer must watch queueFull before it strobes.
  noPushWhileFull: assert property (
    @(posedge clk) disable iff (!reset)
    !(push && full)
  ) else $error("operandQueue push while full");

  // The sequencer must only pop a waiting pair.
  noPopWhileEmpty: assert property (
    @(posedge clk) disable iff (!reset)
    !(pop && empty)
  ) else $error("operandQueue pop while empty");

endmodule

/* mulQueuePkg.sv */
package mulQueuePkg;

  // Operand pairs that can wait while one pair is multiplied.
  localparam int queueDepth = 4;

  // Read and write pointers wrap naturally at queueDepth.
  localparam int queuePtrWidth = 2;

endpackage

/* mulArithPkg.sv */
package mulArithPkg;

  // Operand and product sizes of the signed multiplier.
  localparam int operandWidth = 16;
  localparam int productWidth = 2 * operandWidth;

  // Step counter walks one multiplier bit per cycle.
  localparam int stepWidth = 4;

  // Index of the operand sign bit, which carries negative weight.
  localparam logic [stepWidth-1:0] lastStep = stepWidth'(operandWidth - 1);

endpackage
